// File: source/adc_ctrl_params.svh
`ifndef ADC_CTRL_PARAMS_SVH
`define ADC_CTRL_PARAMS_SVH

// serial clock half period is 2**this sys_clk cycles
// default 3 gives sclk = sys_clk / 16
`define ADC_SCLK_DIV_LOG2 3

// bits per control frame, shifted msb first
// reg_addr and reg_data take the low 20, header the rest
`define ADC_FRAME_BITS 32

`endif

// File: source/adc_ctrl_pkg.sv
`include "adc_ctrl_params.svh"

package adc_ctrl_pkg;

	// decoded view of a control frame
	// header sits on top so it goes out first
	typedef struct packed {
		logic [`ADC_FRAME_BITS-21:0] header;
		logic [3:0]                  reg_addr;
		logic [15:0]                 reg_data;
	} adc_frame_fields_t;

	// one frame word, seen raw by the shifter, by field from software
	typedef union packed {
		logic [`ADC_FRAME_BITS-1:0] raw;
		adc_frame_fields_t          fields;
	} adc_frame_u;

	// processor write, one beat per cycle
	typedef struct packed {
		logic        we;
		logic [1:0]  addr;
		logic [31:0] wdata;
	} bus_req_t;

	// job for the sequencer
	// sel bit 0 is converter 0, bit 1 is converter 1
	typedef struct packed {
		logic [1:0] sel;
		adc_frame_u frame;
	} adc_work_t;

	// sequencer states
	typedef enum logic [2:0] {
		st_idle,
		st_chip_sel,
		st_shift,
		st_release,
		st_wait_req_low
	} ctrl_state_e;

endpackage

// File: source/adc_sclk_gen.sv
`timescale 1ns/1ps
`include "adc_ctrl_params.svh"

module adc_sclk_gen (
	input  logic sys_clk,
	input  logic rst_n,
	output logic sclk,
	output logic sclk_rise,
	output logic sclk_fall
);

	// one bit above the half period count
	localparam int cnt_w = `ADC_SCLK_DIV_LOG2 + 1;

	logic [cnt_w-1:0] div_cnt;
	logic             half_end;

	// free running, never stopped by a transfer
	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// top bit is the serial clock, low after reset
	assign sclk = div_cnt[cnt_w-1];

	// low bits all ones, top bit flips on the next edge
	assign half_end = &div_cnt[cnt_w-2:0];

	// strobes lead the sclk edge by one sys_clk cycle
	assign sclk_rise = half_end && !sclk;
	assign sclk_fall = half_end && sclk;

endmodule

// File: source/adc_spi_shifter.sv
`timescale 1ns/1ps
`include "adc_ctrl_params.svh"

module adc_spi_shifter
	import adc_ctrl_pkg::*;
(
	input  logic       sys_clk,
	input  logic       rst_n,
	input  logic       load,
	input  adc_frame_u frame,
	input  logic       shift_en,
	output logic       sdata,
	output logic       last_bit
);

	localparam int               cnt_w    = $clog2(`ADC_FRAME_BITS);
	localparam logic [cnt_w-1:0] last_idx = cnt_w'(`ADC_FRAME_BITS - 1);

	logic [`ADC_FRAME_BITS-1:0] shift_q;
	logic [cnt_w-1:0]           bit_cnt;

	// frame bits, current bit always at the top
	always_ff @(posedge sys_clk) begin
		if (load) begin
			shift_q <= frame.raw;
		end else if (shift_en) begin
			shift_q <= {shift_q[`ADC_FRAME_BITS-2:0], 1'b0};
		end
	end

	// index of the bit on sdata, counts down to 0
	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt <= '0;
		end else if (load) begin
			bit_cnt <= last_idx;
		end else if (shift_en && (bit_cnt != '0)) begin
			bit_cnt <= bit_cnt - 1'b1;
		end
	end

	// msb first
	assign sdata    = shift_q[`ADC_FRAME_BITS-1];
	// bit 0 showing
	assign last_bit = (bit_cnt == '0);

endmodule

// File: source/adc_serial_ctrl.sv
`timescale 1ns/1ps

module adc_serial_ctrl
	import adc_ctrl_pkg::*;
(
	input  logic       sys_clk,
	input  logic       rst_n,
	input  adc_work_t  work,
	input  logic       work_req,
	output logic       work_ack,
	input  logic       sclk_fall,
	output logic [1:0] not_scs,
	output logic       sdata
);

	ctrl_state_e state;
	ctrl_state_e state_nxt;
	logic        load;
	logic        shift_en;
	logic        shift_bit;
	logic        last_bit;
	logic        cs_on;

	adc_spi_shifter shifter_inst (
		.sys_clk  (sys_clk),
		.rst_n    (rst_n),
		.load     (load),
		.frame    (work.frame),
		.shift_en (shift_en),
		.sdata    (shift_bit),
		.last_bit (last_bit)
	);

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
		end else begin
			state <= state_nxt;
		end
	end

	// serial steps only on sclk_fall, so outputs move with sclk going low
	// one lead-in sclk rise with cs low and sdata low before bit 31
	always_comb begin
		state_nxt = state;
		load      = 1'b0;
		shift_en  = 1'b0;
		case (state)
			st_idle: begin
				// grab the frame as cs drops
				if (sclk_fall && work_req) begin
					state_nxt = st_chip_sel;
					load      = 1'b1;
				end
			end
			st_chip_sel: begin
				// bit 31 appears on entry to shift
				if (sclk_fall) begin
					state_nxt = st_shift;
				end
			end
			st_shift: begin
				if (sclk_fall) begin
					if (last_bit) begin
						// bit 0 has had its rising edge
						state_nxt = st_release;
					end else begin
						shift_en = 1'b1;
					end
				end
			end
			st_release: begin
				// ack is up here, req drops next
				state_nxt = st_wait_req_low;
			end
			st_wait_req_low: begin
				// handshake closes on sys_clk, no sclk wait
				if (!work_req) begin
					state_nxt = st_idle;
				end
			end
			default: begin
				state_nxt = st_idle;
			end
		endcase
	end

	// cs low from chip_sel through the last bit
	assign cs_on   = (state == st_chip_sel) || (state == st_shift);
	// only the selected converters see it
	assign not_scs = ~(work.sel & {2{cs_on}});

	// line held low outside the data bits
	assign sdata = (state == st_shift) && shift_bit;

	// ack up with cs released, down once req is gone
	assign work_ack = (state == st_release) || (state == st_wait_req_low);

endmodule

// File: source/opb_adc_regs.sv
`timescale 1ns/1ps

module opb_adc_regs
	import adc_ctrl_pkg::*;
(
	input  logic        sys_clk,
	input  logic        rst_n,
	input  bus_req_t    bus,
	output logic [31:0] bus_rdata,
	output adc_work_t   work,
	output logic        work_req,
	input  logic        work_ack
);

	// register map
	localparam logic [1:0] addr_frame = 2'd0;
	localparam logic [1:0] addr_conf  = 2'd1;

	adc_frame_u frame_q;
	logic [1:0] sel_q;
	logic       busy;
	logic       frame_we;
	logic       conf_we;
	logic       start;

	assign frame_we = bus.we && (bus.addr == addr_frame);
	assign conf_we  = bus.we && (bus.addr == addr_conf);

	// go bit in wdata[0], dropped while busy or with no converter picked
	assign start = conf_we && bus.wdata[0] && !busy && (bus.wdata[2:1] != 2'b00);

	// frame scratch, software may rewrite it during a transfer
	always_ff @(posedge sys_clk) begin
		if (frame_we) begin
			frame_q.raw <= bus.wdata;
		end
	end

	// select bits, readable back at addr 1
	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			sel_q <= 2'b00;
		end else if (conf_we) begin
			sel_q <= bus.wdata[2:1];
		end
	end

	// snapshot on start
	// stays put from req rise until ack fall
	always_ff @(posedge sys_clk) begin
		if (start) begin
			work.sel   <= bus.wdata[2:1];
			work.frame <= frame_q;
		end
	end

	// req side of the four-phase handshake
	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			work_req <= 1'b0;
			busy     <= 1'b0;
		end else begin
			if (start) begin
				work_req <= 1'b1;
				busy     <= 1'b1;
			end else if (work_req && work_ack) begin
				// frame out, cs released
				work_req <= 1'b0;
			end else if (busy && !work_req && !work_ack) begin
				// ack back low, handshake closed
				busy <= 1'b0;
			end
		end
	end

	// read mux, straight from the address
	always_comb begin
		case (bus.addr)
			addr_frame: bus_rdata = frame_q.raw;
			addr_conf:  bus_rdata = {29'd0, sel_q, busy};
			default:    bus_rdata = 32'd0;
		endcase
	end

endmodule

// File: source/opb_adc083000ctrl.sv
`timescale 1ns/1ps

module opb_adc083000ctrl
	import adc_ctrl_pkg::*;
(
	input  logic        sys_clk,
	input  logic        rst_n,
	input  bus_req_t    bus,
	output logic [31:0] bus_rdata,
	output logic        adc0_not_scs,
	output logic        adc0_sclk,
	output logic        adc0_sdata,
	output logic        adc1_not_scs,
	output logic        adc1_sclk,
	output logic        adc1_sdata
);

	adc_work_t  work;
	logic       work_req;
	logic       work_ack;
	logic       sclk;
	logic       sclk_fall;
	logic [1:0] not_scs;
	logic       sdata;

	// software side, holds frame and select, owns req
	opb_adc_regs regs_inst (
		.sys_clk   (sys_clk),
		.rst_n     (rst_n),
		.bus       (bus),
		.bus_rdata (bus_rdata),
		.work      (work),
		.work_req  (work_req),
		.work_ack  (work_ack)
	);

	// converters sample on the rising edge, nothing here needs that strobe
	adc_sclk_gen sclk_gen_inst (
		.sys_clk   (sys_clk),
		.rst_n     (rst_n),
		.sclk      (sclk),
		.sclk_rise (),
		.sclk_fall (sclk_fall)
	);

	// cs and data sequencing, ack side
	adc_serial_ctrl serial_ctrl_inst (
		.sys_clk   (sys_clk),
		.rst_n     (rst_n),
		.work      (work),
		.work_req  (work_req),
		.work_ack  (work_ack),
		.sclk_fall (sclk_fall),
		.not_scs   (not_scs),
		.sdata     (sdata)
	);

	// clock and data shared, one cs per converter
	assign adc0_sclk    = sclk;
	assign adc1_sclk    = sclk;
	assign adc0_sdata   = sdata;
	assign adc1_sdata   = sdata;
	assign adc0_not_scs = not_scs[0];
	assign adc1_not_scs = not_scs[1];

endmodule

// File: dv/opb_adc083000ctrl_chk.sv
`timescale 1ns/1ps

module opb_adc083000ctrl_chk
	import adc_ctrl_pkg::*;
(
	input logic        sys_clk,
	input logic        rst_n,
	input adc_work_t   work,
	input logic        work_req,
	input logic        work_ack,
	input logic        sclk_fall,
	input logic [1:0]  not_scs,
	input logic        sdata,
	input ctrl_state_e state
);

	// cs low only while the register block holds req
	cs_under_req: assert property (@(posedge sys_clk) disable iff (!rst_n)
		(not_scs != 2'b11) |-> work_req)
		else $error("chip select low without work_req");

	// job held still from load until the handshake closes
	work_stable: assert property (@(posedge sys_clk) disable iff (!rst_n)
		(state != st_idle) |-> $stable(work))
		else $error("work changed while the sequencer was busy");

	// ack answers a live req
	ack_after_req: assert property (@(posedge sys_clk) disable iff (!rst_n)
		$rose(work_ack) |-> work_req)
		else $error("work_ack rose without work_req");

	// req may not drop before ack
	req_held: assert property (@(posedge sys_clk) disable iff (!rst_n)
		(work_req && !work_ack) |=> work_req)
		else $error("work_req dropped before work_ack");

	// data moves with sclk going low
	sdata_on_fall: assert property (@(posedge sys_clk) disable iff (!rst_n)
		!$stable(sdata) |-> $past(sclk_fall))
		else $error("sdata changed away from an sclk_fall cycle");

endmodule

// File: dv/tb_opb_adc083000ctrl.sv
`timescale 1ns/1ps
`include "adc_ctrl_params.svh"

// one converter's view of the serial port
module adc_listener (
	input  logic        not_scs,
	input  logic        sclk,
	input  logic        sdata,
	output logic [63:0] word,
	output int          bits,
	output int          drops
);

	logic [63:0] shift_in;
	int          count;

	initial begin
		word  = '0;
		bits  = 0;
		drops = 0;
		forever begin
			@(negedge not_scs);
			drops++;
			shift_in = '0;
			count    = 0;
			// sample on every sclk rise while selected
			while (!not_scs) begin
				@(posedge sclk or posedge not_scs);
				if (!not_scs) begin
					shift_in = {shift_in[62:0], sdata};
					count++;
				end
			end
			word = shift_in;
			bits = count;
		end
	end

endmodule

module tb_opb_adc083000ctrl
	import adc_ctrl_pkg::*;
();

	localparam int fb         = `ADC_FRAME_BITS;
	localparam int sclk_per   = 2 << `ADC_SCLK_DIV_LOG2;
	// 14 frames of about 34 sclk periods, plus margin
	localparam int max_cycles = 14 * 34 * sclk_per + 1384;

	logic        sys_clk;
	logic        rst_n;
	bus_req_t    bus;
	logic [31:0] bus_rdata;
	logic        adc0_not_scs;
	logic        adc0_sclk;
	logic        adc0_sdata;
	logic        adc1_not_scs;
	logic        adc1_sclk;
	logic        adc1_sdata;

	logic [63:0] got_word [2];
	int          got_bits [2];
	int          got_drops [2];
	int          drops_seen [2];
	logic [fb-1:0] exp_word;
	logic [1:0]  exp_sel;
	event        do_compare;
	event        compare_done;
	integer      seed;
	int          cycles;
	int          errors;
	int          err_mark;
	int          test_num;
	int          tests_failed;

	opb_adc083000ctrl opb_adc083000ctrl_inst (
		.sys_clk      (sys_clk),
		.rst_n        (rst_n),
		.bus          (bus),
		.bus_rdata    (bus_rdata),
		.adc0_not_scs (adc0_not_scs),
		.adc0_sclk    (adc0_sclk),
		.adc0_sdata   (adc0_sdata),
		.adc1_not_scs (adc1_not_scs),
		.adc1_sclk    (adc1_sclk),
		.adc1_sdata   (adc1_sdata)
	);

	bind adc_serial_ctrl opb_adc083000ctrl_chk chk_inst (
		.sys_clk   (sys_clk),
		.rst_n     (rst_n),
		.work      (work),
		.work_req  (work_req),
		.work_ack  (work_ack),
		.sclk_fall (sclk_fall),
		.not_scs   (not_scs),
		.sdata     (sdata),
		.state     (state)
	);

	adc_listener adc0_listen_inst (
		.not_scs (adc0_not_scs),
		.sclk    (adc0_sclk),
		.sdata   (adc0_sdata),
		.word    (got_word[0]),
		.bits    (got_bits[0]),
		.drops   (got_drops[0])
	);

	adc_listener adc1_listen_inst (
		.not_scs (adc1_not_scs),
		.sclk    (adc1_sclk),
		.sdata   (adc1_sdata),
		.word    (got_word[1]),
		.bits    (got_bits[1]),
		.drops   (got_drops[1])
	);

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	// run limit
	always @(posedge sys_clk) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("timeout: run still going after %0d cycles", cycles);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// expected word by the frame layout, header on top
	function automatic logic [fb-1:0] ref_frame(input logic [fb-21:0] hdr,
		input logic [3:0] reg_addr, input logic [15:0] reg_data);
		return {hdr, reg_addr, reg_data};
	endfunction

	task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] got);
		assert (exp == got) else begin
			$display("MISMATCH at %0t: %s expected %0h actual %0h", $time, name, exp, got);
			errors++;
		end
	endtask

	// selected converters get one frame, the others none
	always begin
		@(do_compare);
		for (int i = 0; i < 2; i++) begin
			if (exp_sel[i]) begin
				check_val($sformatf("adc%0d frames", i), 64'(drops_seen[i] + 1), 64'(got_drops[i]));
				// lead-in rise with sdata low, then the data bits
				check_val($sformatf("adc%0d sclk rises", i), 64'(fb + 1), 64'(got_bits[i]));
				check_val($sformatf("adc%0d word", i), 64'(exp_word), got_word[i]);
			end else begin
				check_val($sformatf("adc%0d frames", i), 64'(drops_seen[i]), 64'(got_drops[i]));
			end
			drops_seen[i] = got_drops[i];
		end
		-> compare_done;
	end

	task automatic bus_write(input logic [1:0] addr, input logic [31:0] data);
		@(negedge sys_clk);
		bus.we    = 1'b1;
		bus.addr  = addr;
		bus.wdata = data;
		@(negedge sys_clk);
		bus.we    = 1'b0;
	endtask

	task automatic bus_read(input logic [1:0] addr, output logic [31:0] data);
		@(negedge sys_clk);
		bus.we   = 1'b0;
		bus.addr = addr;
		#1;
		data = bus_rdata;
	endtask

	task automatic wait_idle();
		logic [31:0] rd;
		bus_read(2'd1, rd);
		while (rd[0]) begin
			bus_read(2'd1, rd);
		end
	endtask

	task automatic run_compare(input logic [fb-1:0] word, input logic [1:0] sel);
		exp_word = word;
		exp_sel  = sel;
		-> do_compare;
		@(compare_done);
	endtask

	task automatic send_frame(input logic [fb-1:0] word, input logic [1:0] sel);
		logic [31:0] rd;
		bus_write(2'd0, word);
		bus_read(2'd0, rd);
		check_val("frame readback", 64'(word), 64'(rd));
		bus_write(2'd1, {29'd0, sel, 1'b1});
		// busy up and select bits back at addr 1
		bus_read(2'd1, rd);
		check_val("conf readback", 64'({29'd0, sel, 1'b1}), 64'(rd));
		wait_idle();
		run_compare(word, sel);
	endtask

	task automatic end_test(input string name);
		test_num++;
		if (errors == err_mark) begin
			$display("test %0d %s: ok", test_num, name);
		end else begin
			$display("test %0d %s: failed", test_num, name);
			tests_failed++;
		end
		err_mark = errors;
	endtask

	initial begin
		logic [31:0]   rd;
		logic [31:0]   rnd;
		logic [fb-21:0] hdr;
		logic [3:0]    ra;
		logic [15:0]   rdat;
		logic [1:0]    sel;
		logic [fb-1:0] first;
		seed         = 15;
		cycles       = 0;
		errors       = 0;
		err_mark     = 0;
		test_num     = 0;
		tests_failed = 0;
		drops_seen   = '{0, 0};
		bus          = '0;
		rst_n        = 1'b0;
		repeat (8) @(posedge sys_clk);
		@(negedge sys_clk);
		rst_n = 1'b1;

		// idle lines out of reset
		check_val("adc0_not_scs", 64'd1, 64'(adc0_not_scs));
		check_val("adc1_not_scs", 64'd1, 64'(adc1_not_scs));
		check_val("adc0_sdata", 64'd0, 64'(adc0_sdata));
		check_val("adc1_sdata", 64'd0, 64'(adc1_sdata));
		bus_read(2'd1, rd);
		check_val("busy", 64'd0, 64'(rd[0]));
		end_test("reset state");

		send_frame(ref_frame(12'h5a3, 4'h9, 16'hc3e1), 2'b01);
		end_test("converter 0 only");

		send_frame(ref_frame(12'h0f1, 4'h2, 16'h8001), 2'b11);
		end_test("both converters");

		// second start mid transfer is dropped
		first = ref_frame(12'ha55, 4'h6, 16'h1234);
		bus_write(2'd0, first);
		bus_write(2'd1, {29'd0, 2'b01, 1'b1});
		bus_read(2'd1, rd);
		check_val("busy", 64'd1, 64'(rd[0]));
		bus_write(2'd0, ref_frame(12'h3c3, 4'hf, 16'hffff));
		bus_write(2'd1, {29'd0, 2'b11, 1'b1});
		wait_idle();
		run_compare(first, 2'b01);
		end_test("start while busy");

		// no converter picked, nothing may move
		bus_write(2'd0, ref_frame(12'h111, 4'h1, 16'h1111));
		bus_write(2'd1, 32'h0000_0001);
		bus_read(2'd1, rd);
		check_val("busy", 64'd0, 64'(rd[0]));
		repeat (3 * sclk_per) @(negedge sys_clk);
		run_compare('0, 2'b00);
		end_test("zero select");

		for (int n = 0; n < 10; n++) begin
			rnd  = $random(seed);
			hdr  = rnd[fb-21:0];
			rnd  = $random(seed);
			ra   = rnd[3:0];
			rdat = rnd[31:16];
			rnd  = $random(seed);
			// 1 to 3, never empty
			sel  = (rnd[1:0] % 2'd3) + 2'd1;
			send_frame(ref_frame(hdr, ra, rdat), sel);
		end
		end_test("random frames");

		$display("tests %0d, failed %0d, errors %0d", test_num, tests_failed, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: opb_adc083000ctrl.f
+incdir+source
source/adc_ctrl_pkg.sv
source/adc_sclk_gen.sv
source/adc_spi_shifter.sv
source/adc_serial_ctrl.sv
source/opb_adc_regs.sv
source/opb_adc083000ctrl.sv
dv/opb_adc083000ctrl_chk.sv
dv/tb_opb_adc083000ctrl.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_opb_adc083000ctrl \
	-f opb_adc083000ctrl.f -Mdir obj_dir

out="$(./obj_dir/Vtb_opb_adc083000ctrl)"
echo "$out"

if echo "$out" | grep -qx "PASS: all tests"; then
	exit 0
fi
exit 1
